// File: design/ps_bus_pkg.sv
/*
 * Shared bus definitions for the processor-side bridge
 * Widths, vector types, register map, response codes, bridge states
 */
`default_nettype none

package ps_bus_pkg;

  // Bus widths
  localparam int AW = 32;
  localparam int DW = 32;
  localparam int IW = 12;

  typedef logic [AW-1:0]   addr_t;
  typedef logic [DW-1:0]   data_t;
  typedef logic [DW/8-1:0] strb_t;
  typedef logic [IW-1:0]   id_t;
  typedef logic [1:0]      resp_t;

  // AXI response codes in use
  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  // Housekeeping register byte offsets
  localparam addr_t REG_ID      = 'h00;
  localparam addr_t REG_CTRL    = 'h04;
  localparam addr_t REG_THRESH  = 'h08;
  localparam addr_t REG_COUNT   = 'h0C;
  localparam addr_t REG_SCRATCH = 'h10;

  // Identification word of the register block
  localparam data_t BLOCK_ID = 32'h4853_4B01;

  // CTRL bit positions
  localparam int CTRL_EN_BIT  = 0;
  localparam int CTRL_CLR_BIT = 1;

  // Bridge FSM states
  typedef enum logic [2:0] {
    IDLE,
    WR_WAIT,
    WR_ACCESS,
    WR_RESP,
    RD_ACCESS,
    RD_RESP
  } bridge_state_t;

endpackage

`default_nettype wire

// File: design/sys_bus_if.sv
/*
 * Simple system bus with write and read strobes
 * One access in flight, acknowledged one cycle after the strobe
 */
`timescale 1ns/1ps
`default_nettype none

interface sys_bus_if (
  input logic clk
);

  // Request side
  logic              wen;
  logic              ren;
  ps_bus_pkg::addr_t addr;
  ps_bus_pkg::data_t wdata;
  ps_bus_pkg::strb_t wstrb;

  // Response side
  ps_bus_pkg::data_t rdata;
  logic              ack;
  logic              err;

  // Bridge end
  modport m (input clk, output wen, ren, addr, wdata, wstrb, input rdata, ack, err);

  // Peripheral end
  modport s (input clk, input wen, ren, addr, wdata, wstrb, output rdata, ack, err);

endinterface

`default_nettype wire

// File: design/axi_slave.sv
/*
 * AXI3 single-beat slave bridge
 * Each accepted read or write becomes one system bus access
 * Bursts are refused with SLVERR and never reach the bus
 */
`timescale 1ns/1ps
`default_nettype none

module axi_slave (
  input  logic              clk,
  input  logic              rst_n,
  // Write address channel
  input  logic              awvalid,
  output logic              awready,
  input  ps_bus_pkg::addr_t awaddr,
  input  ps_bus_pkg::id_t   awid,
  input  logic [3:0]        awlen,
  // Write data channel
  input  logic              wvalid,
  output logic              wready,
  input  ps_bus_pkg::data_t wdata,
  input  ps_bus_pkg::strb_t wstrb,
  input  logic              wlast,
  // Write response channel
  output logic              bvalid,
  input  logic              bready,
  output ps_bus_pkg::resp_t bresp,
  output ps_bus_pkg::id_t   bid,
  // Read address channel
  input  logic              arvalid,
  output logic              arready,
  input  ps_bus_pkg::addr_t araddr,
  input  ps_bus_pkg::id_t   arid,
  input  logic [3:0]        arlen,
  // Read data channel
  output logic              rvalid,
  input  logic              rready,
  output ps_bus_pkg::data_t rdata,
  output ps_bus_pkg::resp_t rresp,
  output ps_bus_pkg::id_t   rid,
  output logic              rlast,
  // System bus master
  sys_bus_if.m              bus
);

  ps_bus_pkg::bridge_state_t state;

  // Write halves collected so far
  logic aw_got;
  logic w_got;

  logic aw_hs;
  logic w_hs;
  logic ar_hs;
  logic aw_done;
  logic w_done;
  logic wr_go;
  logic len_err;
  logic wr_len_err;

  // Captured transfer
  ps_bus_pkg::addr_t addr_q;
  ps_bus_pkg::id_t   id_q;
  ps_bus_pkg::data_t wdata_q;
  ps_bus_pkg::strb_t wstrb_q;
  ps_bus_pkg::resp_t resp_q;
  ps_bus_pkg::data_t rdata_q;

  //////////////////////////////////////////////////
  // Address and data acceptance
  //////////////////////////////////////////////////

  // Each write channel closes once its half is held
  assign awready = (state == ps_bus_pkg::IDLE) ||
                   ((state == ps_bus_pkg::WR_WAIT) && !aw_got);
  assign wready  = (state == ps_bus_pkg::IDLE) ||
                   ((state == ps_bus_pkg::WR_WAIT) && !w_got);
  // Write has priority over read
  assign arready = (state == ps_bus_pkg::IDLE) && !awvalid && !wvalid;

  assign aw_hs = awvalid && awready;
  assign w_hs  = wvalid && wready;
  assign ar_hs = arvalid && arready;

  // Write complete when both halves are in, earlier or now
  assign aw_done = aw_got || aw_hs;
  assign w_done  = w_got || (w_hs && wlast);
  assign wr_go   = aw_done && w_done;
  assign len_err = aw_hs ? (awlen != 4'd0) : wr_len_err;

  //////////////////////////////////////////////////
  // Bridge FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ps_bus_pkg::IDLE;
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
      bus.wen <= 1'b0;
      bus.ren <= 1'b0;
    end else begin
      // Strobes are single-cycle pulses
      bus.wen <= 1'b0;
      bus.ren <= 1'b0;
      case (state)
        ps_bus_pkg::IDLE, ps_bus_pkg::WR_WAIT: begin
          if (wr_go) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            if (len_err) begin
              state <= ps_bus_pkg::WR_RESP;
            end else begin
              state   <= ps_bus_pkg::WR_ACCESS;
              bus.wen <= 1'b1;
            end
          end else if (aw_hs || w_hs) begin
            // One half still missing
            aw_got <= aw_done;
            w_got  <= w_done;
            state  <= ps_bus_pkg::WR_WAIT;
          end else if (ar_hs) begin
            if (arlen != 4'd0) begin
              state <= ps_bus_pkg::RD_RESP;
            end else begin
              state   <= ps_bus_pkg::RD_ACCESS;
              bus.ren <= 1'b1;
            end
          end
        end
        ps_bus_pkg::WR_ACCESS: if (bus.ack) state <= ps_bus_pkg::WR_RESP;
        ps_bus_pkg::RD_ACCESS: if (bus.ack) state <= ps_bus_pkg::RD_RESP;
        ps_bus_pkg::WR_RESP:   if (bready) state <= ps_bus_pkg::IDLE;
        ps_bus_pkg::RD_RESP:   if (rready) state <= ps_bus_pkg::IDLE;
        default:               state <= ps_bus_pkg::IDLE;
      endcase
    end
  end

  // Transfer payload
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      addr_q     <= awaddr;
      id_q       <= awid;
      wr_len_err <= (awlen != 4'd0);
    end else if (ar_hs) begin
      addr_q <= araddr;
      id_q   <= arid;
    end
    if (w_hs) begin
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
    // Refused bursts answered without touching the bus
    if (wr_go && len_err) begin
      resp_q <= ps_bus_pkg::RESP_SLVERR;
    end
    if (ar_hs && (arlen != 4'd0)) begin
      resp_q  <= ps_bus_pkg::RESP_SLVERR;
      rdata_q <= '0;
    end
    if (bus.ack && (state == ps_bus_pkg::WR_ACCESS || state == ps_bus_pkg::RD_ACCESS)) begin
      resp_q <= bus.err ? ps_bus_pkg::RESP_SLVERR : ps_bus_pkg::RESP_OKAY;
    end
    if (bus.ack && (state == ps_bus_pkg::RD_ACCESS)) begin
      rdata_q <= bus.rdata;
    end
  end

  //////////////////////////////////////////////////
  // Responses and bus request
  //////////////////////////////////////////////////

  // Held steady until the matching ready
  assign bvalid = (state == ps_bus_pkg::WR_RESP);
  assign bresp  = resp_q;
  assign bid    = id_q;
  assign rvalid = (state == ps_bus_pkg::RD_RESP);
  assign rdata  = rdata_q;
  assign rresp  = resp_q;
  assign rid    = id_q;
  assign rlast  = rvalid;

  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;
  assign bus.wstrb = wstrb_q;

endmodule

`default_nettype wire

// File: design/ctrl_regs.sv
/*
 * Housekeeping register block on the system bus
 * ID, control, threshold, counter readback and scratch registers
 */
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs (
  input  logic              clk,
  input  logic              rst_n,
  sys_bus_if.s              bus,
  output logic              enable,
  output logic              clear,
  output ps_bus_pkg::data_t threshold,
  input  ps_bus_pkg::data_t count
);

  // Decoded window of 4 KB
  localparam int OFFS_W = 12;

  logic [OFFS_W-1:0] offs;
  ps_bus_pkg::data_t ctrl_q;
  ps_bus_pkg::data_t thresh_q;
  ps_bus_pkg::data_t scratch_q;
  ps_bus_pkg::data_t rd_val;
  ps_bus_pkg::data_t wr_merge;
  logic              hit;
  logic              ro;
  logic              acc_err;
  logic              wr_ok;

  // Byte-lane merge under write strobes
  function automatic ps_bus_pkg::data_t merge_bytes(input ps_bus_pkg::data_t old_val,
                                                    input ps_bus_pkg::data_t new_val,
                                                    input ps_bus_pkg::strb_t strb);
    ps_bus_pkg::data_t res;
    res = old_val;
    for (int i = 0; i < ps_bus_pkg::DW/8; i++) begin
      if (strb[i]) res[8*i +: 8] = new_val[8*i +: 8];
    end
    return res;
  endfunction

  assign offs = bus.addr[OFFS_W-1:0];

  // Offset decode
  always_comb begin
    hit      = 1'b1;
    ro       = 1'b0;
    rd_val   = '0;
    wr_merge = '0;
    case (offs)
      ps_bus_pkg::REG_ID[OFFS_W-1:0]: begin
        rd_val = ps_bus_pkg::BLOCK_ID;
        ro     = 1'b1;
      end
      ps_bus_pkg::REG_CTRL[OFFS_W-1:0]: begin
        rd_val   = ctrl_q;
        wr_merge = merge_bytes(ctrl_q, bus.wdata, bus.wstrb);
      end
      ps_bus_pkg::REG_THRESH[OFFS_W-1:0]: begin
        rd_val   = thresh_q;
        wr_merge = merge_bytes(thresh_q, bus.wdata, bus.wstrb);
      end
      ps_bus_pkg::REG_COUNT[OFFS_W-1:0]: begin
        rd_val = count;
        ro     = 1'b1;
      end
      ps_bus_pkg::REG_SCRATCH[OFFS_W-1:0]: begin
        rd_val   = scratch_q;
        wr_merge = merge_bytes(scratch_q, bus.wdata, bus.wstrb);
      end
      default: hit = 1'b0;
    endcase
  end

  // Unmapped offset or write to a read-only register
  assign acc_err = !hit || (bus.wen && ro);
  assign wr_ok   = bus.wen && hit && !ro;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q    <= '0;
      thresh_q  <= '0;
      scratch_q <= '0;
      clear     <= 1'b0;
      bus.ack   <= 1'b0;
      bus.err   <= 1'b0;
    end else begin
      clear   <= 1'b0;
      bus.ack <= bus.wen || bus.ren;
      bus.err <= (bus.wen || bus.ren) && acc_err;
      if (wr_ok) begin
        case (offs)
          ps_bus_pkg::REG_CTRL[OFFS_W-1:0]: begin
            // Clear bit is a strobe and never stored
            ctrl_q <= wr_merge & ~(ps_bus_pkg::data_t'(1) << ps_bus_pkg::CTRL_CLR_BIT);
            clear  <= wr_merge[ps_bus_pkg::CTRL_CLR_BIT];
          end
          ps_bus_pkg::REG_THRESH[OFFS_W-1:0]:  thresh_q  <= wr_merge;
          ps_bus_pkg::REG_SCRATCH[OFFS_W-1:0]: scratch_q <= wr_merge;
          default: ;
        endcase
      end
    end
  end

  // Read data valid alongside ack, zero on error and writes
  always_ff @(posedge clk) begin
    if (bus.wen || bus.ren) bus.rdata <= (acc_err || bus.wen) ? '0 : rd_val;
  end

  assign enable    = ctrl_q[ps_bus_pkg::CTRL_EN_BIT];
  assign threshold = thresh_q;

endmodule

`default_nettype wire

// File: design/edge_counter.sv
/*
 * Event edge counter
 * Synchronizes event input, counts rising edges, flags threshold
 */
`timescale 1ns/1ps
`default_nettype none

module edge_counter #(
  parameter int SYNC_STAGES = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable,
  input  logic              clear,
  input  ps_bus_pkg::data_t threshold,
  input  logic              event_in,
  output ps_bus_pkg::data_t count,
  output logic              irq
);

  // Synchronizer chain and edge history
  logic [SYNC_STAGES-1:0] sync_q;
  logic                   ev_d;
  logic                   ev_rise;

  assign ev_rise = sync_q[SYNC_STAGES-1] && !ev_d;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '0;
      ev_d   <= 1'b0;
    end else begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], event_in};
      ev_d   <= sync_q[SYNC_STAGES-1];
    end
  end

  // Clear wins over counting, saturate at all ones
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (enable && ev_rise && (count != '1)) begin
      count <= count + 1'b1;
    end
  end

  // Threshold of zero disables the interrupt
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq <= 1'b0;
    end else begin
      irq <= (threshold != '0) && (count >= threshold);
    end
  end

endmodule

`default_nettype wire

// File: design/ps_subsys_top.sv
/*
 * Processor-side bus bridge subsystem
 * AXI3 slave, housekeeping registers and event counter
 */
`timescale 1ns/1ps
`default_nettype none

module ps_subsys_top #(
  parameter int SYNC_STAGES = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  // Write address channel
  input  logic              awvalid,
  output logic              awready,
  input  ps_bus_pkg::addr_t awaddr,
  input  ps_bus_pkg::id_t   awid,
  input  logic [3:0]        awlen,
  // Write data channel
  input  logic              wvalid,
  output logic              wready,
  input  ps_bus_pkg::data_t wdata,
  input  ps_bus_pkg::strb_t wstrb,
  input  logic              wlast,
  // Write response channel
  output logic              bvalid,
  input  logic              bready,
  output ps_bus_pkg::resp_t bresp,
  output ps_bus_pkg::id_t   bid,
  // Read address channel
  input  logic              arvalid,
  output logic              arready,
  input  ps_bus_pkg::addr_t araddr,
  input  ps_bus_pkg::id_t   arid,
  input  logic [3:0]        arlen,
  // Read data channel
  output logic              rvalid,
  input  logic              rready,
  output ps_bus_pkg::data_t rdata,
  output ps_bus_pkg::resp_t rresp,
  output ps_bus_pkg::id_t   rid,
  output logic              rlast,
  // Event input and interrupt level
  input  logic              event_in,
  output logic              irq
);

  //////////////////////////////////////////////////
  // Internal connections
  //////////////////////////////////////////////////

  logic              enable;
  logic              clear;
  ps_bus_pkg::data_t threshold;
  ps_bus_pkg::data_t count;

  sys_bus_if bus (.clk(clk));

  //////////////////////////////////////////////////
  // Bridge, registers, counter
  //////////////////////////////////////////////////

  axi_slave u_axi_slave (
    .clk     (clk),     .rst_n   (rst_n),
    .awvalid (awvalid), .awready (awready), .awaddr (awaddr), .awid (awid),
    .awlen   (awlen),
    .wvalid  (wvalid),  .wready  (wready),  .wdata  (wdata),  .wstrb (wstrb),
    .wlast   (wlast),
    .bvalid  (bvalid),  .bready  (bready),  .bresp  (bresp),  .bid   (bid),
    .arvalid (arvalid), .arready (arready), .araddr (araddr), .arid  (arid),
    .arlen   (arlen),
    .rvalid  (rvalid),  .rready  (rready),  .rdata  (rdata),  .rresp (rresp),
    .rid     (rid),     .rlast   (rlast),
    .bus     (bus)
  );

  ctrl_regs u_ctrl_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus       (bus),
    .enable    (enable),
    .clear     (clear),
    .threshold (threshold),
    .count     (count)
  );

  edge_counter #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_edge_counter (
    .clk       (clk),
    .rst_n     (rst_n),
    .enable    (enable),
    .clear     (clear),
    .threshold (threshold),
    .event_in  (event_in),
    .count     (count),
    .irq       (irq)
  );

endmodule

`default_nettype wire

// File: test/ps_subsys_assert.sv
/*
 * Bridge protocol assertions, bound into the AXI slave
 * Response hold under back-pressure, strobe shape, reset state
 */
`timescale 1ns/1ps
`default_nettype none

module ps_subsys_assert (
  input logic              clk,
  input logic              rst_n,
  input logic              bvalid,
  input logic              bready,
  input ps_bus_pkg::resp_t bresp,
  input ps_bus_pkg::id_t   bid,
  input logic              rvalid,
  input logic              rready,
  input ps_bus_pkg::data_t rdata,
  input ps_bus_pkg::resp_t rresp,
  input ps_bus_pkg::id_t   rid,
  input logic              wen,
  input logic              ren
);

  // Failed assertions so far
  int fails = 0;

  // Write response held until BREADY
  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp) && $stable(bid))
    else begin
      $error("BVALID or its payload changed before BREADY");
      fails++;
    end

  // Read response held until RREADY
  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp) && $stable(rid))
    else begin
      $error("RVALID or its payload changed before RREADY");
      fails++;
    end

  a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n) !(wen && ren))
    else begin
      $error("wen and ren high together");
      fails++;
    end

  // Strobes are single-cycle pulses
  a_wen_pulse: assert property (@(posedge clk) disable iff (!rst_n) wen |=> !wen)
    else begin
      $error("wen held longer than one cycle");
      fails++;
    end

  a_ren_pulse: assert property (@(posedge clk) disable iff (!rst_n) ren |=> !ren)
    else begin
      $error("ren held longer than one cycle");
      fails++;
    end

  // Bridge quiet through reset
  a_rst_quiet: assert property (@(posedge clk)
    !rst_n |=> !wen && !ren && !bvalid && !rvalid)
    else begin
      $error("Bridge outputs active during reset");
      fails++;
    end

endmodule

bind axi_slave ps_subsys_assert i_axi_assert (
  .clk    (clk),
  .rst_n  (rst_n),
  .bvalid (bvalid),
  .bready (bready),
  .bresp  (bresp),
  .bid    (bid),
  .rvalid (rvalid),
  .rready (rready),
  .rdata  (rdata),
  .rresp  (rresp),
  .rid    (rid),
  .wen    (bus.wen),
  .ren    (bus.ren)
);

`default_nettype wire

// File: test/ps_subsys_checker.sv
/*
 * Response checker at the subsystem ports
 * Compares B and R handshakes and the irq level with the current row
 * Address channels stay closed while a response is pending
 */
`timescale 1ns/1ps
`default_nettype none

module ps_subsys_checker (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              awready,
  input  logic              wready,
  input  logic              arready,
  input  logic              bvalid,
  input  logic              bready,
  input  ps_bus_pkg::resp_t bresp,
  input  ps_bus_pkg::id_t   bid,
  input  logic              rvalid,
  input  logic              rready,
  input  ps_bus_pkg::data_t rdata,
  input  ps_bus_pkg::resp_t rresp,
  input  ps_bus_pkg::id_t   rid,
  input  logic              rlast,
  input  logic              irq,
  // Expectations of the running row
  input  logic              irq_chk,
  input  logic [8*12-1:0]   name,
  input  ps_bus_pkg::data_t exp_data,
  input  ps_bus_pkg::resp_t exp_resp,
  input  ps_bus_pkg::id_t   exp_id,
  input  logic              exp_irq,
  output int                tests,
  output int                errors
);

  int n_tests = 0;
  int n_errors = 0;
  int row_err = 0;

  assign tests  = n_tests;
  assign errors = n_errors;

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Mismatch %0s %0s expected 0x%08h actual 0x%08h", name, what, exp, act);
      row_err++;
    end
  endtask

  // One line per finished test
  task automatic finish_test();
    n_tests++;
    n_errors += row_err;
    if (row_err == 0) begin
      $display("ok      %0s", name);
    end else begin
      $display("failed  %0s with %0d mismatches", name, row_err);
    end
    row_err = 0;
  endtask

  //////////////////////////////////////////////////
  // Sampling on the clock edge
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    // No new address or data while B or R is outstanding
    if (rst_n && (bvalid || rvalid) && (awready || wready || arready)) begin
      $display("Address or data ready raised while a response is pending in %0s", name);
      row_err++;
    end
    if (rst_n && bvalid && bready) begin
      compare("bresp", 32'(exp_resp), 32'(bresp));
      compare("bid", 32'(exp_id), 32'(bid));
      finish_test();
    end
    if (rst_n && rvalid && rready) begin
      compare("rdata", exp_data, rdata);
      compare("rresp", 32'(exp_resp), 32'(rresp));
      compare("rid", 32'(exp_id), 32'(rid));
      compare("rlast", 32'd1, 32'(rlast));
      compare("irq", 32'(exp_irq), 32'(irq));
      finish_test();
    end
    // Event rows check the interrupt level only
    if (rst_n && irq_chk) begin
      compare("irq", 32'(exp_irq), 32'(irq));
      finish_test();
    end
  end

endmodule

`default_nettype wire

// File: test/ps_subsys_tb.sv
/*
 * Testbench for the processor-side bus bridge subsystem
 * Table-driven AXI reads, writes and event pulses with random ready delays
 */
`timescale 1ns/1ps
`default_nettype none

module ps_subsys_tb;

  localparam int SYNC_STAGES = 2;
  localparam int N_ROWS = 33;
  // Budget of 64 cycles for each row
  localparam int LIMIT = N_ROWS * 64;
  localparam int K_WR = 0;
  localparam int K_RD = 1;
  localparam int K_EV = 2;
  localparam ps_bus_pkg::resp_t OK  = ps_bus_pkg::RESP_OKAY;
  localparam ps_bus_pkg::resp_t ERR = ps_bus_pkg::RESP_SLVERR;

  logic              clk;
  logic              rst_n;
  logic              awvalid, awready, wvalid, wready, wlast;
  logic              bvalid, bready, arvalid, arready;
  logic              rvalid, rready, rlast, event_in, irq;
  logic [3:0]        awlen, arlen;
  ps_bus_pkg::addr_t awaddr, araddr;
  ps_bus_pkg::id_t   awid, bid, arid, rid;
  ps_bus_pkg::data_t wdata, rdata;
  ps_bus_pkg::strb_t wstrb;
  ps_bus_pkg::resp_t bresp, rresp;

  // Expectations handed to the checker
  logic              irq_chk;
  logic [8*12-1:0]   cur_name;
  ps_bus_pkg::data_t exp_data;
  ps_bus_pkg::resp_t exp_resp;
  ps_bus_pkg::id_t   exp_id;
  logic              exp_irq;
  int                chk_tests;
  int                chk_errors;

  int seed = 65;
  int cycles = 0;

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////

  int                tbl_kind   [N_ROWS];
  logic [8*12-1:0]   tbl_name   [N_ROWS];
  ps_bus_pkg::addr_t tbl_addr   [N_ROWS];
  ps_bus_pkg::data_t tbl_data   [N_ROWS];
  ps_bus_pkg::strb_t tbl_strb   [N_ROWS];
  int                tbl_len    [N_ROWS];
  int                tbl_pulses [N_ROWS];
  ps_bus_pkg::data_t tbl_exp    [N_ROWS];
  ps_bus_pkg::resp_t tbl_resp   [N_ROWS];
  logic              tbl_irq    [N_ROWS];
  int                n_rows = 0;

  ps_subsys_top #(.SYNC_STAGES(SYNC_STAGES)) i_dut (.*);

  ps_subsys_checker i_chk (
    .clk      (clk),      .rst_n    (rst_n),
    .awready  (awready),  .wready   (wready),   .arready (arready),
    .bvalid   (bvalid),   .bready   (bready),   .bresp (bresp), .bid (bid),
    .rvalid   (rvalid),   .rready   (rready),   .rdata (rdata), .rresp (rresp),
    .rid      (rid),      .rlast    (rlast),    .irq   (irq),
    .irq_chk  (irq_chk),  .name     (cur_name), .exp_data (exp_data),
    .exp_resp (exp_resp), .exp_id   (exp_id),   .exp_irq  (exp_irq),
    .tests    (chk_tests), .errors  (chk_errors)
  );

  task automatic add_row(input int kind, input logic [8*12-1:0] name,
                         input ps_bus_pkg::addr_t addr, input ps_bus_pkg::data_t data,
                         input ps_bus_pkg::strb_t strb, input int len, input int pulses,
                         input ps_bus_pkg::data_t exp, input ps_bus_pkg::resp_t resp,
                         input logic irq_exp);
    tbl_kind[n_rows]   = kind;
    tbl_name[n_rows]   = name;
    tbl_addr[n_rows]   = addr;
    tbl_data[n_rows]   = data;
    tbl_strb[n_rows]   = strb;
    tbl_len[n_rows]    = len;
    tbl_pulses[n_rows] = pulses;
    tbl_exp[n_rows]    = exp;
    tbl_resp[n_rows]   = resp;
    tbl_irq[n_rows]    = irq_exp;
    n_rows++;
  endtask

  task automatic build_table();
    add_row(K_RD, "id_read", ps_bus_pkg::REG_ID, '0, '0, 0, 0, ps_bus_pkg::BLOCK_ID, OK, 0);
    // Byte lanes of the scratch register
    add_row(K_WR, "scr_full", ps_bus_pkg::REG_SCRATCH, 32'h1234_5678, 4'hF, 0, 0, '0, OK, 0);
    add_row(K_RD, "scr_rd1", ps_bus_pkg::REG_SCRATCH, '0, '0, 0, 0, 32'h1234_5678, OK, 0);
    add_row(K_WR, "scr_part", ps_bus_pkg::REG_SCRATCH, 32'hAABB_CCDD, 4'h5, 0, 0, '0, OK, 0);
    add_row(K_RD, "scr_rd2", ps_bus_pkg::REG_SCRATCH, '0, '0, 0, 0, 32'h12BB_56DD, OK, 0);
    add_row(K_WR, "scr_top", ps_bus_pkg::REG_SCRATCH, 32'hEE00_0000, 4'h8, 0, 0, '0, OK, 0);
    add_row(K_RD, "scr_rd3", ps_bus_pkg::REG_SCRATCH, '0, '0, 0, 0, 32'hEEBB_56DD, OK, 0);
    // Refused accesses
    add_row(K_WR, "id_write", ps_bus_pkg::REG_ID, 32'h0, 4'hF, 0, 0, '0, ERR, 0);
    add_row(K_RD, "id_rd2", ps_bus_pkg::REG_ID, '0, '0, 0, 0, ps_bus_pkg::BLOCK_ID, OK, 0);
    add_row(K_WR, "cnt_write", ps_bus_pkg::REG_COUNT, 32'h5, 4'hF, 0, 0, '0, ERR, 0);
    add_row(K_WR, "unm_write", 32'h40, 32'h1, 4'hF, 0, 0, '0, ERR, 0);
    add_row(K_RD, "unm_read", 32'h40, '0, '0, 0, 0, '0, ERR, 0);
    add_row(K_WR, "burst_wr", ps_bus_pkg::REG_SCRATCH, 32'h0, 4'hF, 3, 0, '0, ERR, 0);
    add_row(K_RD, "burst_rd", ps_bus_pkg::REG_SCRATCH, '0, '0, 1, 0, '0, ERR, 0);
    add_row(K_RD, "scr_rd4", ps_bus_pkg::REG_SCRATCH, '0, '0, 0, 0, 32'hEEBB_56DD, OK, 0);
    // Counter enable and clear
    add_row(K_EV, "ev_disabled", '0, '0, '0, 0, 3, '0, OK, 0);
    add_row(K_RD, "cnt_rd0", ps_bus_pkg::REG_COUNT, '0, '0, 0, 0, 32'h0, OK, 0);
    add_row(K_WR, "enable", ps_bus_pkg::REG_CTRL, 32'h1, 4'hF, 0, 0, '0, OK, 0);
    add_row(K_EV, "ev_four", '0, '0, '0, 0, 4, '0, OK, 0);
    add_row(K_RD, "cnt_rd4", ps_bus_pkg::REG_COUNT, '0, '0, 0, 0, 32'h4, OK, 0);
    add_row(K_WR, "clear", ps_bus_pkg::REG_CTRL, 32'h3, 4'hF, 0, 0, '0, OK, 0);
    add_row(K_RD, "ctrl_rd", ps_bus_pkg::REG_CTRL, '0, '0, 0, 0, 32'h1, OK, 0);
    add_row(K_RD, "cnt_rd0b", ps_bus_pkg::REG_COUNT, '0, '0, 0, 0, 32'h0, OK, 0);
    // Threshold interrupt
    add_row(K_WR, "thresh3", ps_bus_pkg::REG_THRESH, 32'h3, 4'hF, 0, 0, '0, OK, 0);
    add_row(K_EV, "ev_two", '0, '0, '0, 0, 2, '0, OK, 0);
    add_row(K_EV, "ev_third", '0, '0, '0, 0, 1, '0, OK, 1);
    add_row(K_RD, "cnt_rd3", ps_bus_pkg::REG_COUNT, '0, '0, 0, 0, 32'h3, OK, 1);
    add_row(K_WR, "thresh0", ps_bus_pkg::REG_THRESH, 32'h0, 4'hF, 0, 0, '0, OK, 0);
    add_row(K_RD, "irq_off", ps_bus_pkg::REG_COUNT, '0, '0, 0, 0, 32'h3, OK, 0);
    add_row(K_WR, "thresh3b", ps_bus_pkg::REG_THRESH, 32'h3, 4'h1, 0, 0, '0, OK, 0);
    add_row(K_EV, "ev_irq", '0, '0, '0, 0, 1, '0, OK, 1);
    add_row(K_WR, "clear_b", ps_bus_pkg::REG_CTRL, 32'h3, 4'h1, 0, 0, '0, OK, 0);
    add_row(K_RD, "irq_clr", ps_bus_pkg::REG_COUNT, '0, '0, 0, 0, 32'h0, OK, 0);
  endtask

  function automatic ps_bus_pkg::id_t id_of(input int r);
    return ps_bus_pkg::id_t'(12'h3A0 + r);
  endfunction

  //////////////////////////////////////////////////
  // AXI driver tasks
  //////////////////////////////////////////////////

  task automatic write_access(input int r);
    logic aw_pend;
    logic w_pend;
    int   w_lag;
    aw_pend = 1'b1;
    w_pend  = 1'b1;
    w_lag   = $random(seed) & 1;
    awaddr  <= tbl_addr[r];
    awid    <= id_of(r);
    awlen   <= 4'(tbl_len[r]);
    awvalid <= 1'b1;
    wdata   <= tbl_data[r];
    wstrb   <= tbl_strb[r];
    wlast   <= 1'b1;
    // Data channel sometimes a cycle behind the address
    wvalid  <= (w_lag == 0);
    while (aw_pend || w_pend) begin
      @(posedge clk);
      if (awvalid && awready) begin
        aw_pend = 1'b0;
        awvalid <= 1'b0;
      end
      if (wvalid && wready) begin
        w_pend = 1'b0;
        wvalid <= 1'b0;
      end else if (w_pend) begin
        wvalid <= 1'b1;
      end
    end
  endtask

  task automatic read_access(input int r);
    araddr  <= tbl_addr[r];
    arid    <= id_of(r);
    arlen   <= 4'(tbl_len[r]);
    arvalid <= 1'b1;
    @(posedge clk);
    while (!(arvalid && arready)) @(posedge clk);
    arvalid <= 1'b0;
  endtask

  // Random 0 to 3 cycles before ready rises
  task automatic take_response(input logic is_wr);
    int dly;
    dly = {$random(seed)} % 4;
    repeat (dly) @(posedge clk);
    if (is_wr) bready <= 1'b1;
    else rready <= 1'b1;
    @(posedge clk);
    while (!(is_wr ? (bvalid && bready) : (rvalid && rready))) @(posedge clk);
    bready <= 1'b0;
    rready <= 1'b0;
  endtask

  task automatic pulse_events(input int r);
    repeat (tbl_pulses[r]) begin
      @(posedge clk);
      event_in <= 1'b1;
      @(posedge clk);
      @(posedge clk);
      event_in <= 1'b0;
      @(posedge clk);
    end
    // Synchronizer, edge detect and irq register
    repeat (SYNC_STAGES + 2) @(posedge clk);
    irq_chk <= 1'b1;
    @(posedge clk);
    irq_chk <= 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Clock, timeout, main sequence
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == LIMIT) begin
      $display("Timeout: the test run did not finish within %0d cycles", LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    int total;
    rst_n    = 1'b0;
    awvalid  = 1'b0;
    awaddr   = '0;
    awid     = '0;
    awlen    = '0;
    wvalid   = 1'b0;
    wdata    = '0;
    wstrb    = '0;
    wlast    = 1'b0;
    bready   = 1'b0;
    arvalid  = 1'b0;
    araddr   = '0;
    arid     = '0;
    arlen    = '0;
    rready   = 1'b0;
    event_in = 1'b0;
    irq_chk  = 1'b0;
    cur_name = '0;
    exp_data = '0;
    exp_resp = '0;
    exp_id   = '0;
    exp_irq  = 1'b0;
    build_table();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int r = 0; r < n_rows; r++) begin
      cur_name <= tbl_name[r];
      exp_data <= tbl_exp[r];
      exp_resp <= tbl_resp[r];
      exp_id   <= id_of(r);
      exp_irq  <= tbl_irq[r];
      case (tbl_kind[r])
        K_WR: begin
          write_access(r);
          take_response(1'b1);
        end
        K_RD: begin
          read_access(r);
          take_response(1'b0);
        end
        default: pulse_events(r);
      endcase
    end
    repeat (2) @(posedge clk);
    total = chk_errors + i_dut.u_axi_slave.i_axi_assert.fails;
    if (chk_tests != n_rows) begin
      $display("Checker finished %0d of %0d tests", chk_tests, n_rows);
    end
    $display("Tests run: %0d, errors: %0d", chk_tests, total);
    if (total == 0 && chk_tests == n_rows) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ps_subsys.f
design/ps_bus_pkg.sv
design/sys_bus_if.sv
design/axi_slave.sv
design/ctrl_regs.sv
design/edge_counter.sv
design/ps_subsys_top.sv
test/ps_subsys_assert.sv
test/ps_subsys_checker.sv
test/ps_subsys_tb.sv
